// ==== hdl/frame_pkg.sv ====
package frame_pkg;

  localparam int DATA_W = 8; // one header byte per beat
  localparam int DEST_W = 6;

  // top two header bits
  typedef enum logic [1:0] {
    OP_FORWARD = 2'd0,
    OP_DROP    = 2'd1,
    OP_RSVD2   = 2'd2, // handled as drop
    OP_RSVD3   = 2'd3  // handled as drop
  } hdr_op_t;

  // header byte as it arrives on the stream
  typedef struct packed {
    hdr_op_t           op;
    logic [DEST_W-1:0] dest;
  } hdr_t;

  typedef enum logic {
    CLS_HEAD = 1'b0, // next beat is a header
    CLS_BODY = 1'b1
  } cls_state_t;

endpackage

// ==== hdl/stats_pkg.sv ====
package stats_pkg;

  // outcome of one frame at the FIFO write side
  // only one frame can end per cycle, so one event at a time
  typedef enum logic [2:0] {
    EV_NONE     = 3'd0,
    EV_GOOD     = 3'd1,
    EV_BAD      = 3'd2,
    EV_OVERFLOW = 3'd3
  } frame_event_t;

endpackage

// ==== hdl/axis_if.sv ====
`timescale 1ns/1ps

interface axis_if
  import frame_pkg::*;
();

  logic [DATA_W-1:0] tdata;
  logic              tvalid;
  logic              tready;
  logic              tlast;
  logic [DEST_W-1:0] tdest;
  logic              tuser; // bad frame, valid with tlast

  modport src (
    output tdata, tvalid, tlast, tdest, tuser,
    input  tready
  );

  modport snk (
    input  tdata, tvalid, tlast, tdest, tuser,
    output tready
  );

endinterface

// ==== hdl/frame_classifier.sv ====
`timescale 1ns/1ps

module frame_classifier
  import frame_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [DATA_W-1:0] s_tdata,
  input  logic              s_tvalid,
  output logic              s_tready,
  input  logic              s_tlast,
  axis_if.src               out,
  output logic              runt
);

  cls_state_t        state;
  hdr_t              hdr_in;
  hdr_op_t           op_reg;
  logic [DEST_W-1:0] dest_reg;
  logic [DATA_W-1:0] xor_reg;
  logic [DATA_W-1:0] xor_next;
  logic              accept;
  logic              out_valid_reg;
  logic [DATA_W-1:0] out_data_reg;
  logic              out_last_reg;
  logic              out_bad_reg;

  assign hdr_in   = hdr_t'(s_tdata);
  assign xor_next = xor_reg ^ s_tdata;

  // single output slot, free when empty or draining this cycle
  assign s_tready = !out_valid_reg || out.tready;
  assign accept   = s_tvalid && s_tready;

  assign out.tvalid = out_valid_reg;
  assign out.tdata  = out_data_reg;
  assign out.tlast  = out_last_reg;
  assign out.tuser  = out_bad_reg;
  // dest_reg only reloads on a header, after the last beat has left the slot
  assign out.tdest  = dest_reg;

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= CLS_HEAD;
      out_valid_reg <= 1'b0;
      runt          <= 1'b0;
    end else begin
      runt <= 1'b0;
      if (out.tready) begin
        out_valid_reg <= 1'b0;
      end
      if (accept) begin
        case (state)
          CLS_HEAD: begin
            if (s_tlast) begin
              runt <= 1'b1; // header with no payload
            end else begin
              state <= CLS_BODY;
            end
          end
          CLS_BODY: begin
            out_valid_reg <= 1'b1;
            if (s_tlast) begin
              state <= CLS_HEAD;
            end
          end
          default: state <= CLS_HEAD;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      if (state == CLS_HEAD) begin
        op_reg   <= hdr_in.op;
        dest_reg <= hdr_in.dest;
        xor_reg  <= s_tdata; // header is part of the check
      end else begin
        xor_reg      <= xor_next;
        out_data_reg <= s_tdata;
        out_last_reg <= s_tlast;
        // flag decided on the check byte itself
        out_bad_reg  <= s_tlast && ((op_reg != OP_FORWARD) || (xor_next != '0));
      end
    end
  end

endmodule

// ==== hdl/axis_fifo.sv ====
`timescale 1ns/1ps

module axis_fifo
  import frame_pkg::*;
  import stats_pkg::*;
#(
  parameter int ADDR_WIDTH = 4
)
(
  input  logic         clk,
  input  logic         rst,
  axis_if.snk          in,
  axis_if.src          out,
  output frame_event_t fifo_event
);

  localparam int WIDTH = DATA_W + DEST_W + 1; // data, dest, last

  logic [ADDR_WIDTH:0] wr_ptr_reg;
  logic [ADDR_WIDTH:0] wr_ptr_next;
  logic [ADDR_WIDTH:0] wr_ptr_cur_reg;
  logic [ADDR_WIDTH:0] wr_ptr_cur_next;
  logic [ADDR_WIDTH:0] rd_ptr_reg;
  logic [ADDR_WIDTH:0] rd_ptr_next;

  logic [WIDTH-1:0] mem [2**ADDR_WIDTH];
  logic [WIDTH-1:0] mem_read_data_reg;
  logic             mem_read_data_valid_reg;
  logic             mem_read_data_valid_next;
  logic [WIDTH-1:0] out_reg;
  logic             out_valid_reg;
  logic             out_valid_next;

  logic         full_cur;
  logic         full_wr;
  logic         empty;
  logic         write;
  logic         read;
  logic         store_output;
  logic         drop_frame_reg;
  logic         drop_frame_next;
  frame_event_t event_next;

  // current frame ran into unread data
  assign full_cur = (wr_ptr_cur_reg[ADDR_WIDTH] != rd_ptr_reg[ADDR_WIDTH]) &&
                    (wr_ptr_cur_reg[ADDR_WIDTH-1:0] == rd_ptr_reg[ADDR_WIDTH-1:0]);
  // current frame alone fills the whole buffer
  assign full_wr  = (wr_ptr_reg[ADDR_WIDTH] != wr_ptr_cur_reg[ADDR_WIDTH]) &&
                    (wr_ptr_reg[ADDR_WIDTH-1:0] == wr_ptr_cur_reg[ADDR_WIDTH-1:0]);
  assign empty    = wr_ptr_reg == rd_ptr_reg; // only committed frames are visible

  assign in.tready = 1'b1; // drop when full, never back-pressure

  assign out.tvalid = out_valid_reg;
  assign out.tdata  = out_reg[DATA_W-1:0];
  assign out.tdest  = out_reg[DATA_W +: DEST_W];
  assign out.tlast  = out_reg[WIDTH-1];
  assign out.tuser  = 1'b0; // bad frames never leave the buffer

  always_comb begin
    write           = 1'b0;
    drop_frame_next = drop_frame_reg;
    event_next      = EV_NONE;
    wr_ptr_next     = wr_ptr_reg;
    wr_ptr_cur_next = wr_ptr_cur_reg;
    if (in.tvalid && in.tready) begin
      if (full_cur || full_wr || drop_frame_reg) begin
        drop_frame_next = 1'b1; // swallow the rest of the frame
        if (in.tlast) begin
          wr_ptr_cur_next = wr_ptr_reg;
          drop_frame_next = 1'b0;
          event_next      = EV_OVERFLOW;
        end
      end else begin
        write           = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur_reg + 1'b1;
        if (in.tlast) begin
          if (in.tuser) begin
            wr_ptr_cur_next = wr_ptr_reg; // rewind
            event_next      = EV_BAD;
          end else begin
            wr_ptr_next = wr_ptr_cur_reg + 1'b1; // commit
            event_next  = EV_GOOD;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_reg     <= '0;
      wr_ptr_cur_reg <= '0;
      drop_frame_reg <= 1'b0;
      fifo_event     <= EV_NONE;
    end else begin
      wr_ptr_reg     <= wr_ptr_next;
      wr_ptr_cur_reg <= wr_ptr_cur_next;
      drop_frame_reg <= drop_frame_next;
      fifo_event     <= event_next;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_ptr_cur_reg[ADDR_WIDTH-1:0]] <= {in.tlast, in.tdest, in.tdata};
    end
  end

  // first stage, memory read register
  always_comb begin
    read                     = 1'b0;
    rd_ptr_next              = rd_ptr_reg;
    mem_read_data_valid_next = mem_read_data_valid_reg;
    if (store_output || !mem_read_data_valid_reg) begin
      if (!empty) begin
        read                     = 1'b1;
        mem_read_data_valid_next = 1'b1;
        rd_ptr_next              = rd_ptr_reg + 1'b1;
      end else begin
        mem_read_data_valid_next = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr_reg              <= '0;
      mem_read_data_valid_reg <= 1'b0;
    end else begin
      rd_ptr_reg              <= rd_ptr_next;
      mem_read_data_valid_reg <= mem_read_data_valid_next;
    end
    if (read) begin
      mem_read_data_reg <= mem[rd_ptr_reg[ADDR_WIDTH-1:0]];
    end
  end

  // second stage, output register
  always_comb begin
    store_output   = 1'b0;
    out_valid_next = out_valid_reg;
    if (out.tready || !out_valid_reg) begin
      store_output   = 1'b1;
      out_valid_next = mem_read_data_valid_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_reg <= 1'b0;
    end else begin
      out_valid_reg <= out_valid_next;
    end
    if (store_output) begin
      out_reg <= mem_read_data_reg;
    end
  end

endmodule

// ==== hdl/frame_stats.sv ====
`timescale 1ns/1ps

module frame_stats
  import stats_pkg::*;
#(
  parameter int COUNT_WIDTH = 16
)
(
  input  logic                   clk,
  input  logic                   rst,
  input  frame_event_t           fifo_event,
  input  logic                   runt,
  output logic [COUNT_WIDTH-1:0] good_count,
  output logic [COUNT_WIDTH-1:0] bad_count,
  output logic [COUNT_WIDTH-1:0] overflow_count,
  output logic [COUNT_WIDTH-1:0] runt_count
);

  localparam int N_CNT = 4;
  localparam int I_GOOD = 0;
  localparam int I_BAD = 1;
  localparam int I_OVF = 2;
  localparam int I_RUNT = 3;

  logic [N_CNT-1:0]       hit;
  logic [COUNT_WIDTH-1:0] cnt [N_CNT];

  // one hot per cycle from the event code
  assign hit[I_GOOD] = fifo_event == EV_GOOD;
  assign hit[I_BAD]  = fifo_event == EV_BAD;
  assign hit[I_OVF]  = fifo_event == EV_OVERFLOW;
  assign hit[I_RUNT] = runt;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < N_CNT; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N_CNT; i++) begin
        if (hit[i] && (cnt[i] != '1)) begin // hold at max
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  assign good_count     = cnt[I_GOOD];
  assign bad_count      = cnt[I_BAD];
  assign overflow_count = cnt[I_OVF];
  assign runt_count     = cnt[I_RUNT];

endmodule

// ==== hdl/frame_filter_top.sv ====
`timescale 1ns/1ps

module frame_filter_top
  import frame_pkg::*;
  import stats_pkg::*;
#(
  parameter int ADDR_WIDTH  = 4,
  parameter int COUNT_WIDTH = 16
)
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [DATA_W-1:0]      s_axis_tdata,
  input  logic                   s_axis_tvalid,
  output logic                   s_axis_tready,
  input  logic                   s_axis_tlast,
  output logic [DATA_W-1:0]      m_axis_tdata,
  output logic [DEST_W-1:0]      m_axis_tdest,
  output logic                   m_axis_tvalid,
  input  logic                   m_axis_tready,
  output logic                   m_axis_tlast,
  output logic [COUNT_WIDTH-1:0] good_count,
  output logic [COUNT_WIDTH-1:0] bad_count,
  output logic [COUNT_WIDTH-1:0] overflow_count,
  output logic [COUNT_WIDTH-1:0] runt_count
);

  axis_if cls_stream ();
  axis_if out_stream ();

  frame_event_t fifo_event;
  logic         runt;

  frame_classifier u_classifier (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (s_axis_tdata),
    .s_tvalid (s_axis_tvalid),
    .s_tready (s_axis_tready),
    .s_tlast  (s_axis_tlast),
    .out      (cls_stream.src),
    .runt     (runt)
  );

  axis_fifo #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_fifo (
    .clk        (clk),
    .rst        (rst),
    .in         (cls_stream.snk),
    .out        (out_stream.src),
    .fifo_event (fifo_event)
  );

  frame_stats #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_stats (
    .clk            (clk),
    .rst            (rst),
    .fifo_event     (fifo_event),
    .runt           (runt),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count),
    .runt_count     (runt_count)
  );

  // output stream out to plain ports, tuser stays inside
  assign m_axis_tdata      = out_stream.tdata;
  assign m_axis_tdest      = out_stream.tdest;
  assign m_axis_tvalid     = out_stream.tvalid;
  assign m_axis_tlast      = out_stream.tlast;
  assign out_stream.tready = m_axis_tready;

endmodule

// ==== tests/frame_model.svh ====
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

localparam int FIFO_DEPTH = 16; // 2**ADDR_WIDTH at the default

integer     seed = 32'h6e371014;
logic [7:0] frame_q[$]; // header, payload, check byte last
logic [7:0] exp_data[$];
logic [5:0] exp_dest[$];
logic       exp_last[$];
int         exp_good = 0;
int         exp_bad  = 0;
int         exp_ovf  = 0;
int         exp_runt = 0;

function automatic int rand_range(input int lo, input int hi);
  return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
endfunction

// len counts payload bytes including the check byte, 0 gives a runt
task automatic build_frame(input logic [1:0] op, input int len, input bit corrupt);
  logic [7:0] hdr;
  logic [7:0] sum;
  logic [7:0] b;
  int         i;
  hdr = {op, 6'(rand_range(0, 63))};
  frame_q.delete();
  frame_q.push_back(hdr);
  sum = hdr;
  for (i = 1; i < len; i++) begin
    b = 8'(rand_range(0, 255));
    frame_q.push_back(b);
    sum ^= b;
  end
  if (len > 0) begin
    if (corrupt) begin
      sum ^= 8'(rand_range(1, 255)); // any nonzero flip
    end
    frame_q.push_back(sum);
  end
endtask

// expected outcome of the frame in frame_q, sent into an empty FIFO
task automatic predict_frame();
  logic [7:0] sum;
  int         len;
  int         i;
  sum = '0;
  len = frame_q.size() - 1;
  for (i = 0; i <= len; i++) begin
    sum ^= frame_q[i];
  end
  if (len == 0) begin
    exp_runt++;
  end else if (len > FIFO_DEPTH) begin
    exp_ovf++; // overflow wins over the bad flag
  end else if ((frame_q[0][7:6] != OP_FORWARD) || (sum != 8'h00)) begin
    exp_bad++;
  end else begin
    exp_good++;
    for (i = 1; i <= len; i++) begin
      exp_data.push_back(frame_q[i]);
      exp_dest.push_back(frame_q[0][5:0]);
      exp_last.push_back(i == len);
    end
  end
endtask

`endif

// ==== tests/frame_filter_tb.sv ====
`timescale 1ns/1ps

module frame_filter_tb
  import frame_pkg::*;
();

  localparam int MAX_BYTES   = 1500; // bound on frame bytes over all tests
  localparam int WATCHDOG_NS = MAX_BYTES * 40 * 40 + 100000;
  localparam int IDLE_LIMIT  = 1000; // cycles for one frame to drain

  logic        clk = 1'b0;
  logic        rst;
  logic [7:0]  s_axis_tdata;
  logic        s_axis_tvalid;
  logic        s_axis_tready;
  logic        s_axis_tlast;
  logic [7:0]  m_axis_tdata;
  logic [5:0]  m_axis_tdest;
  logic        m_axis_tvalid;
  logic        m_axis_tready;
  logic        m_axis_tlast;
  logic [15:0] good_count;
  logic [15:0] bad_count;
  logic [15:0] overflow_count;
  logic [15:0] runt_count;

  string  cur_test = "reset";
  int     test_errors = 0;
  int     total_errors = 0;
  int     tests_failed = 0;
  int     tests_run = 0;
  bit     hold_ready = 1'b0;
  integer ready_seed = 32'h6e371014;

  `include "frame_model.svh"

  frame_filter_top u_frame_filter_top (
    .clk            (clk),
    .rst            (rst),
    .s_axis_tdata   (s_axis_tdata),
    .s_axis_tvalid  (s_axis_tvalid),
    .s_axis_tready  (s_axis_tready),
    .s_axis_tlast   (s_axis_tlast),
    .m_axis_tdata   (m_axis_tdata),
    .m_axis_tdest   (m_axis_tdest),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tready  (m_axis_tready),
    .m_axis_tlast   (m_axis_tlast),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count),
    .runt_count     (runt_count)
  );

  always #20 clk = ~clk;

  task automatic check_count(input string what, input int exp, input int act);
    if (exp != act) begin
      $display("mismatch %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_beat();
    if (exp_data.size() == 0) begin
      $display("%s: beat %h delivered with no frame expected", cur_test, m_axis_tdata);
      test_errors++;
    end else begin
      if (m_axis_tdata !== exp_data[0]) begin
        $display("mismatch %s tdata: expected %h, actual %h", cur_test, exp_data[0], m_axis_tdata);
        test_errors++;
      end
      if (m_axis_tdest !== exp_dest[0]) begin
        $display("mismatch %s tdest: expected %h, actual %h", cur_test, exp_dest[0], m_axis_tdest);
        test_errors++;
      end
      if (m_axis_tlast !== exp_last[0]) begin
        $display("mismatch %s tlast: expected %b, actual %b", cur_test, exp_last[0], m_axis_tlast);
        test_errors++;
      end
      void'(exp_data.pop_front());
      void'(exp_dest.pop_front());
      void'(exp_last.pop_front());
    end
  endtask

  // output monitor, samples on the edge and moves ready 2 ns later
  always @(posedge clk) begin
    if (!rst && m_axis_tvalid && m_axis_tready) begin
      check_beat();
    end
    #2;
    if (hold_ready) begin
      m_axis_tready = 1'b0;
    end else begin
      m_axis_tready = ($random(ready_seed) & 3) != 0; // high about 3 cycles in 4
    end
  end

  task automatic send_frame();
    int i;
    bit took;
    for (i = 0; i < frame_q.size(); i++) begin
      s_axis_tdata  = frame_q[i];
      s_axis_tvalid = 1'b1;
      s_axis_tlast  = i == frame_q.size() - 1;
      do begin
        took = s_axis_tready; // settled since the last edge
        @(posedge clk);
        #2;
      end while (!took);
    end
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
  endtask

  task automatic run_frame(input logic [1:0] op, input int len, input bit corrupt);
    build_frame(op, len, corrupt);
    predict_frame();
    send_frame();
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (exp_data.size() != 0 && n < IDLE_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (exp_data.size() != 0) begin
      $display("%s: %0d beats not delivered within %0d cycles", cur_test, exp_data.size(),
               IDLE_LIMIT);
      test_errors++;
      exp_data.delete();
      exp_dest.delete();
      exp_last.delete();
    end
    repeat (3) @(posedge clk); // counters trail the last input beat by two cycles
    #2;
    check_count("good_count", exp_good, good_count);
    check_count("bad_count", exp_bad, bad_count);
    check_count("overflow_count", exp_ovf, overflow_count);
    check_count("runt_count", exp_runt, runt_count);
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, test_errors);
    end
  endtask

  initial begin
    int i;
    int len1;
    int len2;
    int len3;
    rst           = 1'b1;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    start_test("good_frames");
    for (i = 0; i < 40; i++) begin
      run_frame(OP_FORWARD, rand_range(1, FIFO_DEPTH), 1'b0);
      wait_idle();
    end
    check_count("good_count", 40, good_count);
    finish_test();

    start_test("bad_checksum");
    for (i = 0; i < 20; i++) begin
      run_frame(OP_FORWARD, rand_range(1, FIFO_DEPTH), i % 2 == 1);
      wait_idle();
    end
    finish_test();

    start_test("drop_opcode");
    for (i = 0; i < 12; i++) begin
      run_frame(2'(rand_range(1, 3)), rand_range(1, FIFO_DEPTH), 1'b0);
      wait_idle();
    end
    finish_test();

    start_test("oversize");
    for (i = 0; i < 6; i++) begin
      run_frame(OP_FORWARD, rand_range(FIFO_DEPTH + 1, 24), 1'b0);
      wait_idle();
    end
    run_frame(OP_FORWARD, rand_range(1, FIFO_DEPTH), 1'b0);
    wait_idle();
    finish_test();

    start_test("burst_in_flight");
    hold_ready = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    len1 = rand_range(1, 6);
    len2 = rand_range(1, 5);
    len3 = rand_range(1, FIFO_DEPTH - len1 - len2); // three frames fit the buffer
    run_frame(OP_FORWARD, len1, 1'b0);
    run_frame(OP_FORWARD, len2, 1'b0);
    run_frame(OP_FORWARD, len3, 1'b0);
    repeat (4) @(posedge clk);
    #2;
    if (!m_axis_tvalid) begin
      $display("%s: no beat presented while ready was held low", cur_test);
      test_errors++;
    end else if (m_axis_tdata !== exp_data[0]) begin
      $display("mismatch %s held tdata: expected %h, actual %h", cur_test, exp_data[0],
               m_axis_tdata);
      test_errors++;
    end
    hold_ready = 1'b0;
    wait_idle();
    finish_test();

    start_test("runt");
    for (i = 0; i < 8; i++) begin
      run_frame(2'(rand_range(0, 3)), 0, 1'b0);
      wait_idle();
    end
    finish_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors);
    if (total_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run still busy after %0d ns, stuck in %s", WATCHDOG_NS, cur_test);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+tests
hdl/frame_pkg.sv
hdl/stats_pkg.sv
hdl/axis_if.sv
hdl/frame_classifier.sv
hdl/axis_fifo.sv
hdl/frame_stats.sv
hdl/frame_filter_top.sv
tests/frame_filter_tb.sv
